//--- rtl/mem_arb_defs.svh
`ifndef MEM_ARB_DEFS_SVH
`define MEM_ARB_DEFS_SVH

// Byte address of a cache line
`define MEM_ADDR_W 32

// One bus beat of the banked memory
`define MEM_BEAT_W 64

`define MEM_BEATS 4

// Full cache line, four beats
`define MEM_LINE_W (`MEM_BEATS * `MEM_BEAT_W)

// Outstanding reads tracked at once
`define PEND_DEPTH 16

`endif

//--- rtl/mem_arb_pkg.sv
`include "mem_arb_defs.svh"

package mem_arb_pkg;

    // A line is moved whole to the caches and beat by beat on the bus
    typedef union packed {
        logic [`MEM_LINE_W-1:0]                flat;
        logic [`MEM_BEATS-1:0][`MEM_BEAT_W-1:0] beats;
    } mem_line_u;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic                   write;
        logic                   prefetch;
        mem_line_u              line;
    } line_req_t;

    typedef struct packed {
        mem_line_u line;
        logic      prefetch;
        logic      write;
    } line_resp_t;

    typedef struct packed {
        logic                   valid;
        logic                   for_data;
        logic                   prefetch;
        logic [`MEM_ADDR_W-1:0] addr;
    } pend_entry_t;

    // inst and data also record who was granted last
    typedef enum logic [1:0] {
        idle,
        inst,
        data,
        wr_burst
    } svc_state_t;

endpackage

//--- rtl/arb_fsm.sv
`timescale 1ns/100ps

module arb_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ireq_valid,
    input  logic                    dreq_valid,
    input  logic                    dreq_write,
    input  logic                    bmem_ready,
    input  logic                    table_full,
    input  logic                    burst_last,
    output logic                    ireq_ready,
    output logic                    dreq_ready,
    output logic                    grant_data,
    output mem_arb_pkg::svc_state_t state
);

    mem_arb_pkg::svc_state_t state_next;
    logic                    inst_ok;
    logic                    data_ok;
    logic                    pick_data;

    always_comb begin
        // Reads need a free table slot, writes only need the bus
        inst_ok = ireq_valid && bmem_ready && !table_full;
        data_ok = dreq_valid && bmem_ready && (dreq_write || !table_full);

        // On contention the side not served last time wins
        pick_data = data_ok && (!inst_ok || state == mem_arb_pkg::inst);

        ireq_ready = 1'b0;
        dreq_ready = 1'b0;
        grant_data = 1'b0;
        state_next = state;

        if (state == mem_arb_pkg::wr_burst) begin
            // Bus stays with the write-back until its last beat
            grant_data = 1'b1;
            if (burst_last) begin
                state_next = mem_arb_pkg::data;
            end
        end else if (pick_data) begin
            grant_data = 1'b1;
            dreq_ready = 1'b1;
            state_next = dreq_write ? mem_arb_pkg::wr_burst : mem_arb_pkg::data;
        end else if (inst_ok) begin
            ireq_ready = 1'b1;
            state_next = mem_arb_pkg::inst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_arb_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- rtl/beat_counter.sv
`timescale 1ns/100ps

module beat_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       beat,
    output logic [1:0] count,
    output logic       last
);

    // Four beats per line, so the count wraps on its own
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= 2'd0;
        end else if (beat) begin
            count <= count + 2'd1;
        end
    end

    assign last = beat && (count == 2'd3);

endmodule

//--- rtl/line_assembler.sv
`timescale 1ns/100ps

`include "mem_arb_defs.svh"

module line_assembler (
    input  logic                   clk,
    input  logic                   beat_valid,
    input  logic [1:0]             count,
    input  logic [`MEM_BEAT_W-1:0] rdata,
    output mem_arb_pkg::mem_line_u line
);

    logic [`MEM_BEAT_W-1:0] beat_buf [3];

    // Only beats 0 to 2 are held
    always_ff @(posedge clk) begin
        if (beat_valid && count != 2'd3) begin
            beat_buf[count] <= rdata;
        end
    end

    // The last beat goes straight through from the bus
    always_comb begin
        line.beats[0] = beat_buf[0];
        line.beats[1] = beat_buf[1];
        line.beats[2] = beat_buf[2];
        line.beats[3] = rdata;
    end

endmodule

//--- rtl/write_serializer.sv
`timescale 1ns/100ps

`include "mem_arb_defs.svh"

module write_serializer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  mem_arb_pkg::mem_line_u line_in,
    input  logic                   beat,
    output logic [`MEM_BEAT_W-1:0] wdata
);

    logic [`MEM_BEAT_W-1:0] beat_buf [3];
    logic [1:0]             idx;

    // Beat 0 leaves in the load cycle, the rest wait here
    always_ff @(posedge clk) begin
        if (load) begin
            beat_buf[0] <= line_in.beats[1];
            beat_buf[1] <= line_in.beats[2];
            beat_buf[2] <= line_in.beats[3];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= 2'd0;
        end else if (load) begin
            idx <= 2'd0;
        end else if (beat) begin
            idx <= (idx == 2'd2) ? 2'd0 : idx + 2'd1;
        end
    end

    assign wdata = load ? line_in.beats[0] : beat_buf[idx];

endmodule

//--- rtl/pending_table.sv
`timescale 1ns/100ps

`include "mem_arb_defs.svh"

module pending_table (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alloc,
    input  mem_arb_pkg::pend_entry_t alloc_entry,
    input  logic                     match_valid,
    input  logic [`MEM_ADDR_W-1:0]   match_addr,
    input  mem_arb_pkg::mem_line_u   line,
    output logic                     full,
    output logic                     iresp_valid,
    output logic                     dresp_valid,
    output mem_arb_pkg::line_resp_t  resp
);

    localparam int IDX_W = $clog2(`PEND_DEPTH);

    mem_arb_pkg::pend_entry_t entries [`PEND_DEPTH];
    logic [IDX_W-1:0]         free_idx;
    logic                     free_found;
    logic [IDX_W-1:0]         hit_idx;
    logic                     hit_found;

    // Scanning downward leaves the lowest index in place
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        hit_idx    = '0;
        hit_found  = 1'b0;
        for (int i = `PEND_DEPTH - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                free_idx   = IDX_W'(i);
                free_found = 1'b1;
            end
            if (entries[i].valid && entries[i].addr == match_addr) begin
                hit_idx   = IDX_W'(i);
                hit_found = 1'b1;
            end
        end
    end

    assign full = !free_found;

    always_comb begin
        iresp_valid   = match_valid && hit_found && !entries[hit_idx].for_data;
        dresp_valid   = match_valid && hit_found && entries[hit_idx].for_data;
        resp.line     = line;
        resp.prefetch = entries[hit_idx].prefetch;
        resp.write    = 1'b0;
    end

    // A hit entry is valid, so it never collides with the free slot
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PEND_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else begin
            if (alloc && free_found) begin
                entries[free_idx] <= alloc_entry;
            end
            if (match_valid && hit_found) begin
                entries[hit_idx].valid <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/mem_arbiter.sv
`timescale 1ns/100ps

`include "mem_arb_defs.svh"

module mem_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  mem_arb_pkg::line_req_t  ireq,
    input  logic                    ireq_valid,
    output logic                    ireq_ready,
    input  mem_arb_pkg::line_req_t  dreq,
    input  logic                    dreq_valid,
    output logic                    dreq_ready,
    output mem_arb_pkg::line_resp_t iresp,
    output logic                    iresp_valid,
    output mem_arb_pkg::line_resp_t dresp,
    output logic                    dresp_valid,
    output logic [`MEM_ADDR_W-1:0]  bmem_addr,
    output logic                    bmem_read,
    output logic                    bmem_write,
    output logic [`MEM_BEAT_W-1:0]  bmem_wdata,
    input  logic                    bmem_ready,
    input  logic [`MEM_BEAT_W-1:0]  bmem_rdata,
    input  logic [`MEM_ADDR_W-1:0]  bmem_raddr,
    input  logic                    bmem_rvalid
);

    mem_arb_pkg::svc_state_t  state;
    mem_arb_pkg::mem_line_u   rd_line;
    mem_arb_pkg::line_resp_t  tbl_resp;
    mem_arb_pkg::pend_entry_t alloc_entry;
    logic                     grant_data;
    logic                     table_full;
    logic                     tbl_dresp_valid;
    logic [1:0]               rd_count;
    logic                     rd_last;
    logic [1:0]               wr_count;
    logic                     wr_last;
    logic                     wr_beat;
    logic                     in_burst;
    logic                     ack_stall;
    logic [`MEM_ADDR_W-1:0]   wr_addr;

    arb_fsm arb_fsm_i (
        .clk        (clk),
        .rst        (rst),
        .ireq_valid (ireq_valid),
        .dreq_valid (dreq_valid),
        .dreq_write (dreq.write),
        .bmem_ready (bmem_ready),
        .table_full (table_full),
        .burst_last (wr_last),
        .ireq_ready (ireq_ready),
        .dreq_ready (dreq_ready),
        .grant_data (grant_data),
        .state      (state)
    );

    beat_counter rd_counter_i (
        .clk   (clk),
        .rst   (rst),
        .beat  (bmem_rvalid),
        .count (rd_count),
        .last  (rd_last)
    );

    beat_counter wr_counter_i (
        .clk   (clk),
        .rst   (rst),
        .beat  (wr_beat),
        .count (wr_count),
        .last  (wr_last)
    );

    line_assembler line_assembler_i (
        .clk        (clk),
        .beat_valid (bmem_rvalid),
        .count      (rd_count),
        .rdata      (bmem_rdata),
        .line       (rd_line)
    );

    write_serializer write_serializer_i (
        .clk     (clk),
        .rst     (rst),
        .load    (dreq_ready && dreq.write),
        .line_in (dreq.line),
        .beat    (wr_beat),
        .wdata   (bmem_wdata)
    );

    pending_table pending_table_i (
        .clk         (clk),
        .rst         (rst),
        .alloc       (bmem_read && bmem_ready),
        .alloc_entry (alloc_entry),
        .match_valid (rd_last),
        .match_addr  (bmem_raddr),
        .line        (rd_line),
        .full        (table_full),
        .iresp_valid (iresp_valid),
        .dresp_valid (tbl_dresp_valid),
        .resp        (tbl_resp)
    );

    // Requesters may move on after acceptance, so the burst address is kept here
    always_ff @(posedge clk) begin
        if (dreq_ready && dreq.write) begin
            wr_addr <= dreq.addr;
        end
    end

    assign in_burst = (state == mem_arb_pkg::wr_burst);
    assign wr_beat  = bmem_write && bmem_ready;

    // Hold beat 3 back a cycle if a data fill is completing, dresp carries one at a time
    assign ack_stall = in_burst && (wr_count == 2'd3) && tbl_dresp_valid;

    always_comb begin
        bmem_addr  = ireq.addr;
        bmem_read  = 1'b0;
        bmem_write = 1'b0;
        if (in_burst) begin
            bmem_addr  = wr_addr;
            bmem_write = !ack_stall;
        end else if (dreq_ready) begin
            bmem_addr  = dreq.addr;
            bmem_read  = !dreq.write;
            bmem_write = dreq.write;
        end else if (ireq_ready) begin
            bmem_read = 1'b1;
        end
    end

    always_comb begin
        alloc_entry.valid    = 1'b1;
        alloc_entry.for_data = grant_data;
        alloc_entry.prefetch = grant_data ? dreq.prefetch : ireq.prefetch;
        alloc_entry.addr     = bmem_addr;
    end

    assign iresp = tbl_resp;

    // Write acknowledge shares the data response port
    always_comb begin
        dresp = tbl_resp;
        if (wr_last) begin
            dresp.prefetch = 1'b0;
            dresp.write    = 1'b1;
        end
    end

    assign dresp_valid = tbl_dresp_valid || wr_last;

endmodule

//--- verif/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
    output logic clk,
    output logic rst
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset covers the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- verif/tb_mem_arbiter.sv
`timescale 1ns/100ps

`include "mem_arb_defs.svh"

module tb_mem_arbiter;

    localparam int NUM_TXN        = 400;
    localparam int CYCLES_PER_TXN = 50;
    localparam int MAX_CYCLES     = NUM_TXN * CYCLES_PER_TXN;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic                   for_data;
        logic                   prefetch;
        mem_arb_pkg::mem_line_u exp_line;
        mem_arb_pkg::mem_line_u mem_line;
    } read_rec_t;

    logic                    clk;
    logic                    rst;
    mem_arb_pkg::line_req_t  ireq;
    logic                    ireq_valid;
    logic                    ireq_ready;
    mem_arb_pkg::line_req_t  dreq;
    logic                    dreq_valid;
    logic                    dreq_ready;
    mem_arb_pkg::line_resp_t iresp;
    logic                    iresp_valid;
    mem_arb_pkg::line_resp_t dresp;
    logic                    dresp_valid;
    logic [`MEM_ADDR_W-1:0]  bmem_addr;
    logic                    bmem_read;
    logic                    bmem_write;
    logic [`MEM_BEAT_W-1:0]  bmem_wdata;
    logic                    bmem_ready;
    logic [`MEM_BEAT_W-1:0]  bmem_rdata;
    logic [`MEM_ADDR_W-1:0]  bmem_raddr;
    logic                    bmem_rvalid;

    integer                  seed = 32'ha78a;
    read_rec_t               pend_q [$];
    read_rec_t               burst_rec;
    logic                    burst_on;
    logic [1:0]              burst_beat;
    mem_arb_pkg::line_req_t  wr_req;
    mem_arb_pkg::mem_line_u  wr_seen;
    logic                    in_burst;
    logic [1:0]              wr_idx;
    logic                    last_inst;
    logic                    i_acc;
    logic                    d_acc;
    mem_arb_pkg::mem_line_u  ref_store [logic [`MEM_ADDR_W-1:0]];
    mem_arb_pkg::mem_line_u  mem_store [logic [`MEM_ADDR_W-1:0]];
    int                      issued;
    int                      resp_cnt;
    int                      cycles;
    logic                    done;

    clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    mem_arbiter mem_arbiter_i (.*);

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = rand_word();
        return r[0];
    endfunction

    // Lines never written hold their address plus the beat index
    function automatic mem_arb_pkg::mem_line_u fill_line(input logic [`MEM_ADDR_W-1:0] a);
        mem_arb_pkg::mem_line_u l;
        for (int b = 0; b < `MEM_BEATS; b++) begin
            l.beats[b] = {32'd0, a} + 64'(b);
        end
        return l;
    endfunction

    // Two reads of one line in flight would make the table match ambiguous
    function automatic logic addr_busy(input logic [`MEM_ADDR_W-1:0] a);
        logic busy;
        busy = (ireq_valid && ireq.addr == a) || (dreq_valid && dreq.addr == a);
        busy = busy || (burst_on && burst_rec.addr == a);
        foreach (pend_q[k]) begin
            if (pend_q[k].addr == a) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0d ns: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input logic [`MEM_ADDR_W-1:0] got,
                              input logic [`MEM_ADDR_W-1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0d ns: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_beat(input logic [`MEM_BEAT_W-1:0] got,
                              input logic [`MEM_BEAT_W-1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0d ns: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_resp(input mem_arb_pkg::line_resp_t got,
                              input mem_arb_pkg::line_resp_t exp,
                              input logic with_line, input string what);
        if (got.write !== exp.write || got.prefetch !== exp.prefetch
                || (with_line && got.line.flat !== exp.line.flat)) begin
            abort_run($sformatf("CHECK FAILED at %0d ns: %s got w%b p%b %h, expected w%b p%b %h",
                                $time, what, got.write, got.prefetch, got.line.flat,
                                exp.write, exp.prefetch, exp.line.flat));
        end
    endtask

    task automatic record_read(input logic [`MEM_ADDR_W-1:0] a, input logic for_data,
                               input logic pf);
        read_rec_t r;
        r.addr     = a;
        r.for_data = for_data;
        r.prefetch = pf;
        r.exp_line = ref_store.exists(a) ? ref_store[a] : fill_line(a);
        r.mem_line = mem_store.exists(a) ? mem_store[a] : fill_line(a);
        pend_q.push_back(r);
    endtask

    // Runs mid-cycle, every handshake seen here completes at the next rising edge
    task automatic sample_cycle();
        int                      outstanding;
        int                      k;
        logic                    full;
        logic                    inst_ok;
        logic                    data_ok;
        logic                    exp_i;
        logic                    exp_d;
        logic                    fill;
        logic                    exp_wr;
        logic                    ack;
        mem_arb_pkg::line_resp_t exp_resp;

        outstanding = pend_q.size() + (burst_on ? 1 : 0);
        full    = outstanding >= `PEND_DEPTH;
        inst_ok = ireq_valid && bmem_ready && !full && !in_burst;
        data_ok = dreq_valid && bmem_ready && (dreq.write || !full) && !in_burst;
        exp_d   = data_ok && (!inst_ok || last_inst);
        exp_i   = inst_ok && !exp_d;
        fill    = burst_on && burst_beat == 2'd3;
        // Beat 3 of a write waits while a data fill owns dresp
        exp_wr  = (exp_d && dreq.write)
                  || (in_burst && !(wr_idx == 2'd3 && fill && burst_rec.for_data));
        ack     = in_burst && wr_idx == 2'd3 && exp_wr && bmem_ready;

        check_bit(ireq_ready, exp_i, "ireq_ready");
        check_bit(dreq_ready, exp_d, "dreq_ready");
        check_bit(bmem_read, exp_i || (exp_d && !dreq.write), "bmem_read");
        check_bit(bmem_write, exp_wr, "bmem_write");
        check_bit(iresp_valid, fill && !burst_rec.for_data, "iresp_valid");
        check_bit(dresp_valid, (fill && burst_rec.for_data) || ack, "dresp_valid");

        if (fill) begin
            exp_resp.line     = burst_rec.exp_line;
            exp_resp.prefetch = burst_rec.prefetch;
            exp_resp.write    = 1'b0;
            check_resp(burst_rec.for_data ? dresp : iresp, exp_resp, 1'b1, "read fill");
            burst_on = 1'b0;
            resp_cnt++;
        end
        if (ack) begin
            exp_resp.line     = '0;
            exp_resp.prefetch = 1'b0;
            exp_resp.write    = 1'b1;
            check_resp(dresp, exp_resp, 1'b0, "write acknowledge");
        end

        if (exp_i) begin
            check_addr(bmem_addr, ireq.addr, "instruction read address");
            record_read(ireq.addr, 1'b0, ireq.prefetch);
            last_inst = 1'b1;
        end
        if (exp_d) begin
            last_inst = 1'b0;
            if (dreq.write) begin
                wr_req   = dreq;
                wr_idx   = 2'd0;
                in_burst = 1'b1;
                ref_store[dreq.addr] = dreq.line;
            end else begin
                check_addr(bmem_addr, dreq.addr, "data read address");
                record_read(dreq.addr, 1'b1, dreq.prefetch);
            end
        end

        // Checked also under low ready, the beat must hold
        if (exp_wr) begin
            check_addr(bmem_addr, wr_req.addr, "write address");
            check_beat(bmem_wdata, wr_req.line.beats[wr_idx], "write beat");
            if (bmem_ready) begin
                wr_seen.beats[wr_idx] = bmem_wdata;
                if (wr_idx == 2'd3) begin
                    mem_store[wr_req.addr] = wr_seen;
                    in_burst = 1'b0;
                end
                wr_idx = wr_idx + 2'd1;
            end
        end

        // Memory picks any pending read, so bursts come back out of order
        if (burst_on) begin
            burst_beat = burst_beat + 2'd1;
        end else if (pend_q.size() > 0 && rand_bit()) begin
            k          = int'(rand_word() % 32'(pend_q.size()));
            burst_rec  = pend_q[k];
            pend_q.delete(k);
            burst_on   = 1'b1;
            burst_beat = 2'd0;
        end
        i_acc = exp_i;
        d_acc = exp_d;
    endtask

    task automatic drive_cycle();
        logic [`MEM_ADDR_W-1:0] a;

        if (i_acc) begin
            ireq_valid = 1'b0;
        end
        if (d_acc) begin
            dreq_valid = 1'b0;
        end

        a = 32'h0004_0000 | (rand_word() & 32'h0000_07e0);
        if (!ireq_valid && issued < NUM_TXN && (rand_word() & 32'd3) == 0 && !addr_busy(a)) begin
            ireq.addr     = a;
            ireq.write    = 1'b0;
            ireq.prefetch = rand_bit();
            ireq_valid    = 1'b1;
            issued++;
        end

        a = 32'h0004_0000 | (rand_word() & 32'h0000_07e0);
        if (!dreq_valid && issued < NUM_TXN && (rand_word() & 32'd3) == 0 && !addr_busy(a)) begin
            dreq.addr     = a;
            dreq.write    = (rand_word() & 32'd3) == 0;
            dreq.prefetch = dreq.write ? 1'b0 : rand_bit();
            for (int w = 0; w < `MEM_LINE_W / 32; w++) begin
                dreq.line.flat[32*w +: 32] = rand_word();
            end
            dreq_valid = 1'b1;
            issued++;
        end

        bmem_ready  = (rand_word() & 32'd7) != 0;
        bmem_rvalid = burst_on;
        bmem_raddr  = burst_rec.addr;
        bmem_rdata  = burst_rec.mem_line.beats[burst_beat];
    endtask

    initial begin
        ireq        = '0;
        ireq_valid  = 1'b0;
        dreq        = '0;
        dreq_valid  = 1'b0;
        bmem_ready  = 1'b0;
        bmem_rdata  = '0;
        bmem_raddr  = '0;
        bmem_rvalid = 1'b0;
        burst_rec   = '0;
        burst_on    = 1'b0;
        burst_beat  = 2'd0;
        wr_req      = '0;
        wr_seen     = '0;
        in_burst    = 1'b0;
        wr_idx      = 2'd0;
        last_inst   = 1'b0;
        i_acc       = 1'b0;
        d_acc       = 1'b0;
        issued      = 0;
        resp_cnt    = 0;
        cycles      = 0;
        done        = 1'b0;

        @(negedge rst);
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                abort_run($sformatf("Timeout: traffic did not drain within %0d cycles",
                                    MAX_CYCLES));
            end
            sample_cycle();
            @(posedge clk);
            #1;
            drive_cycle();
            done = issued == NUM_TXN && !ireq_valid && !dreq_valid && pend_q.size() == 0
                   && !burst_on && !in_burst;
        end

        $display("%0d transactions, %0d reads answered", issued, resp_cnt);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- files.f
+incdir+rtl
rtl/mem_arb_pkg.sv
rtl/arb_fsm.sv
rtl/beat_counter.sv
rtl/line_assembler.sv
rtl/write_serializer.sv
rtl/pending_table.sv
rtl/mem_arbiter.sv
verif/clk_gen.sv
verif/tb_mem_arbiter.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build tb_mem_arbiter with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f files.f --top-module tb_mem_arbiter
	./obj_dir/Vtb_mem_arbiter | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
